// ==== source/ntm_pkg.sv ====
////////////////////
// Shared widths, operation codes and limits for the fixed-point adder tree
// Referenced by scoped names from RTL and testbench
////////////////////

package ntm_pkg;

  ////////////////////
  // Data format
  ////////////////////

  // Signed Q8.8 element
  localparam int DATA_SIZE = 16;
  localparam int FRAC_SIZE = 8;

  // Row and column sizes and counters
  localparam int INDEX_SIZE = 8;
  localparam logic [INDEX_SIZE-1:0] INDEX_ONE = 1;

  ////////////////////
  // Operation codes
  ////////////////////

  localparam logic OP_ADD = 1'b0;
  localparam logic OP_SUB = 1'b1;

  // Saturation limits, most positive and most negative element
  localparam logic signed [DATA_SIZE-1:0] DATA_MAX = {1'b0, {(DATA_SIZE-1){1'b1}}};
  localparam logic signed [DATA_SIZE-1:0] DATA_MIN = {1'b1, {(DATA_SIZE-1){1'b0}}};

  ////////////////////
  // Matrix FSM encoding
  ////////////////////

  localparam logic [1:0] MATRIX_IDLE = 2'd0;
  localparam logic [1:0] MATRIX_RUN  = 2'd1;
  localparam logic [1:0] MATRIX_LAST = 2'd2;

endpackage

// ==== source/scalar_fixed_adder.sv ====
////////////////////
// Saturating add or subtract of one Q8.8 operand pair
// One register stage from OPERAND_ENABLE to RESULT_ENABLE
////////////////////

`timescale 1ns/10ps

module scalar_fixed_adder (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         OPERAND_ENABLE,
  input  logic                         OPERATION,
  input  logic [ntm_pkg::DATA_SIZE-1:0] DATA_A_IN,
  input  logic [ntm_pkg::DATA_SIZE-1:0] DATA_B_IN,
  output logic                         RESULT_ENABLE,
  output logic [ntm_pkg::DATA_SIZE-1:0] DATA_OUT
);

  // Operands sign extended by one bit
  logic [ntm_pkg::DATA_SIZE:0] a_ext;
  logic [ntm_pkg::DATA_SIZE:0] b_ext;
  logic [ntm_pkg::DATA_SIZE:0] sum_ext;
  logic                        overflow;
  logic [ntm_pkg::DATA_SIZE-1:0] sum_sat;

  assign a_ext = {DATA_A_IN[ntm_pkg::DATA_SIZE-1], DATA_A_IN};
  assign b_ext = {DATA_B_IN[ntm_pkg::DATA_SIZE-1], DATA_B_IN};

  // Binary point lines up on both sides so no shift is needed
  always_comb begin
    case (OPERATION)
      ntm_pkg::OP_ADD: sum_ext = a_ext + b_ext;
      ntm_pkg::OP_SUB: sum_ext = a_ext - b_ext;
      default:         sum_ext = a_ext + b_ext;
    endcase
  end

  // Top two bits differ on signed overflow
  assign overflow = sum_ext[ntm_pkg::DATA_SIZE] ^ sum_ext[ntm_pkg::DATA_SIZE-1];

  // Clamp toward the sign of the true result
  assign sum_sat = !overflow                   ? sum_ext[ntm_pkg::DATA_SIZE-1:0] :
                   sum_ext[ntm_pkg::DATA_SIZE] ? ntm_pkg::DATA_MIN :
                                                 ntm_pkg::DATA_MAX;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      RESULT_ENABLE <= 1'b0;
    end else begin
      RESULT_ENABLE <= OPERAND_ENABLE;
    end
  end

  // Result word
  always_ff @(posedge CLK) begin
    if (OPERAND_ENABLE) begin
      DATA_OUT <= sum_sat;
    end
  end

endmodule

// ==== source/vector_fixed_adder.sv ====
////////////////////
// Row sequencer: pairs A and B elements, feeds the scalar adder
// Three edges from complete pair to DATA_OUT_ENABLE, READY on last result of a row
////////////////////

`timescale 1ns/10ps

module vector_fixed_adder (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           START,
  input  logic                           OPERATION,
  input  logic [ntm_pkg::INDEX_SIZE-1:0] SIZE_IN,
  input  logic                           DATA_A_IN_ENABLE,
  input  logic                           DATA_B_IN_ENABLE,
  input  logic [ntm_pkg::DATA_SIZE-1:0]  DATA_A_IN,
  input  logic [ntm_pkg::DATA_SIZE-1:0]  DATA_B_IN,
  output logic                           DATA_OUT_ENABLE,
  output logic                           READY,
  output logic [ntm_pkg::DATA_SIZE-1:0]  DATA_OUT
);

  // Operand side, index 0 is A and 1 is B
  logic [1:0]                    in_enable;
  logic [1:0]                    full;
  logic [1:0]                    avail;
  logic [ntm_pkg::DATA_SIZE-1:0] in_data [2];
  logic [ntm_pkg::DATA_SIZE-1:0] pick [2];
  logic                          pair_issue;

  // Row settings
  logic                           op_reg;
  logic                           op_sel;
  logic [ntm_pkg::INDEX_SIZE-1:0] size_reg;
  logic [ntm_pkg::INDEX_SIZE-1:0] result_cnt;

  // Operand register stage
  logic                          opnd_enable;
  logic                          opnd_op;
  logic [ntm_pkg::DATA_SIZE-1:0] opnd_a;
  logic [ntm_pkg::DATA_SIZE-1:0] opnd_b;

  // Scalar adder answer
  logic                          result_enable;
  logic [ntm_pkg::DATA_SIZE-1:0] result_data;

  assign in_enable  = {DATA_B_IN_ENABLE, DATA_A_IN_ENABLE};
  assign in_data[0] = DATA_A_IN;
  assign in_data[1] = DATA_B_IN;

  // An operand counts as present when held or arriving now
  assign avail      = full | in_enable;
  assign pair_issue = &avail;

  // First pair of a row may issue in the START cycle itself
  assign op_sel = START ? OPERATION : op_reg;

  ////////////////////
  // Holding registers
  ////////////////////

  for (genvar k = 0; k < 2; k++) begin : g_hold
    logic                          full_q;
    logic [ntm_pkg::DATA_SIZE-1:0] hold_q;

    assign full[k] = full_q;
    assign pick[k] = full_q ? hold_q : in_data[k];

    // Held value leaves on issue, a new strobe refills it
    always_ff @(posedge CLK or posedge RST) begin
      if (RST) begin
        full_q <= 1'b0;
      end else if (in_enable[k]) begin
        full_q <= full_q | ~pair_issue;
      end else if (pair_issue) begin
        full_q <= 1'b0;
      end
    end

    // Store when empty and waiting, or when the old one is consumed
    always_ff @(posedge CLK) begin
      if (in_enable[k] && (full_q == pair_issue)) begin
        hold_q <= in_data[k];
      end
    end
  end

  // Operation and row length kept from START
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op_reg   <= ntm_pkg::OP_ADD;
      size_reg <= '0;
    end else if (START) begin
      op_reg   <= OPERATION;
      size_reg <= SIZE_IN;
    end
  end

  ////////////////////
  // Edge 1, pair register
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      opnd_enable <= 1'b0;
    end else begin
      opnd_enable <= pair_issue;
    end
  end

  always_ff @(posedge CLK) begin
    if (pair_issue) begin
      opnd_a  <= pick[0];
      opnd_b  <= pick[1];
      opnd_op <= op_sel;
    end
  end

  // Edge 2 inside the scalar adder
  scalar_fixed_adder scalar_fixed_adder0 (
    .CLK           (CLK),
    .RST           (RST),
    .OPERAND_ENABLE(opnd_enable),
    .OPERATION     (opnd_op),
    .DATA_A_IN     (opnd_a),
    .DATA_B_IN     (opnd_b),
    .RESULT_ENABLE (result_enable),
    .DATA_OUT      (result_data)
  );

  ////////////////////
  // Edge 3, output and row count
  ////////////////////

  // Counter wraps at row end so a following row can already be in flight
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT        <= '0;
      result_cnt      <= '0;
    end else begin
      DATA_OUT_ENABLE <= result_enable;
      READY           <= 1'b0;
      if (result_enable) begin
        DATA_OUT <= result_data;
        if (result_cnt == size_reg - ntm_pkg::INDEX_ONE) begin
          READY      <= 1'b1;
          result_cnt <= '0;
        end else begin
          result_cnt <= result_cnt + ntm_pkg::INDEX_ONE;
        end
      end
    end
  end

endmodule

// ==== source/matrix_fixed_adder.sv ====
////////////////////
// Matrix add/subtract engine, top level
// Latches sizes on START, one vector row per A I enable, frames rows and matrix end
////////////////////

`timescale 1ns/10ps

module matrix_fixed_adder (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           START,
  output logic                           READY,
  input  logic                           OPERATION,
  input  logic                           DATA_A_IN_I_ENABLE,
  input  logic                           DATA_A_IN_J_ENABLE,
  input  logic                           DATA_B_IN_I_ENABLE,
  input  logic                           DATA_B_IN_J_ENABLE,
  output logic                           DATA_OUT_I_ENABLE,
  output logic                           DATA_OUT_J_ENABLE,
  input  logic [ntm_pkg::INDEX_SIZE-1:0] SIZE_I_IN,
  input  logic [ntm_pkg::INDEX_SIZE-1:0] SIZE_J_IN,
  input  logic [ntm_pkg::DATA_SIZE-1:0]  DATA_A_IN,
  input  logic [ntm_pkg::DATA_SIZE-1:0]  DATA_B_IN,
  output logic [ntm_pkg::DATA_SIZE-1:0]  DATA_OUT
);

  // FSM and matrix settings
  logic [1:0]                     state;
  logic                           active;
  logic                           op_reg;
  logic [ntm_pkg::INDEX_SIZE-1:0] size_i_reg;
  logic [ntm_pkg::INDEX_SIZE-1:0] size_j_reg;
  logic [ntm_pkg::INDEX_SIZE-1:0] row_cnt;
  logic                           first_pending;

  // Vector adder side
  logic                          vec_start;
  logic                          vec_a_enable;
  logic                          vec_b_enable;
  logic                          vec_out_enable;
  logic                          vec_ready;
  logic [ntm_pkg::DATA_SIZE-1:0] vec_data_out;
  logic                          row_done;

  assign active = (state != ntm_pkg::MATRIX_IDLE);

  ////////////////////
  // Input forwarding
  ////////////////////

  // Strobes outside an operation are dropped here
  assign vec_start    = active & DATA_A_IN_I_ENABLE;
  assign vec_a_enable = active & (DATA_A_IN_I_ENABLE | DATA_A_IN_J_ENABLE);
  assign vec_b_enable = active & (DATA_B_IN_I_ENABLE | DATA_B_IN_J_ENABLE);

  vector_fixed_adder vector_fixed_adder0 (
    .CLK             (CLK),
    .RST             (RST),
    .START           (vec_start),
    .OPERATION       (op_reg),
    .SIZE_IN         (size_j_reg),
    .DATA_A_IN_ENABLE(vec_a_enable),
    .DATA_B_IN_ENABLE(vec_b_enable),
    .DATA_A_IN       (DATA_A_IN),
    .DATA_B_IN       (DATA_B_IN),
    .DATA_OUT_ENABLE (vec_out_enable),
    .READY           (vec_ready),
    .DATA_OUT        (vec_data_out)
  );

  ////////////////////
  // Output framing
  ////////////////////

  // Vector READY comes with its last result
  assign row_done = active & vec_out_enable & vec_ready;

  // No extra cycle, re-mark of vector strobes
  assign DATA_OUT_J_ENABLE = active & vec_out_enable;
  assign DATA_OUT_I_ENABLE = active & vec_out_enable & first_pending;
  assign READY             = row_done & (state == ntm_pkg::MATRIX_LAST);
  assign DATA_OUT          = vec_data_out;

  ////////////////////
  // Row FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ntm_pkg::MATRIX_IDLE;
      op_reg     <= ntm_pkg::OP_ADD;
      size_i_reg <= '0;
      size_j_reg <= '0;
      row_cnt    <= '0;
    end else begin
      case (state)
        ntm_pkg::MATRIX_IDLE: begin
          if (START) begin
            op_reg     <= OPERATION;
            size_i_reg <= SIZE_I_IN;
            size_j_reg <= SIZE_J_IN;
            row_cnt    <= '0;
            // Single row matrix goes straight to its last row
            if (SIZE_I_IN == ntm_pkg::INDEX_ONE) begin
              state <= ntm_pkg::MATRIX_LAST;
            end else begin
              state <= ntm_pkg::MATRIX_RUN;
            end
          end
        end
        ntm_pkg::MATRIX_RUN: begin
          if (row_done) begin
            row_cnt <= row_cnt + ntm_pkg::INDEX_ONE;
            // Next row is the final one
            if (row_cnt + ntm_pkg::INDEX_ONE == size_i_reg - ntm_pkg::INDEX_ONE) begin
              state <= ntm_pkg::MATRIX_LAST;
            end
          end
        end
        ntm_pkg::MATRIX_LAST: begin
          if (row_done) begin
            state <= ntm_pkg::MATRIX_IDLE;
          end
        end
        default: begin
          state <= ntm_pkg::MATRIX_IDLE;
        end
      endcase
    end
  end

  // Marks the next result as a row start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      first_pending <= 1'b0;
    end else if (!active) begin
      first_pending <= START;
    end else if (vec_out_enable) begin
      first_pending <= vec_ready;
    end
  end

endmodule

// ==== tb/matrix_fixed_adder_asserts.sv ====
////////////////////
// Protocol assertions for the matrix adder, bound to the top level
////////////////////

`timescale 1ns/10ps

module matrix_fixed_adder_asserts (
  input logic CLK,
  input logic RST,
  input logic START,
  input logic active,
  input logic READY,
  input logic DATA_OUT_I_ENABLE,
  input logic DATA_OUT_J_ENABLE
);

  logic out_any;

  assign out_any = READY | DATA_OUT_I_ENABLE | DATA_OUT_J_ENABLE;

  // Matrix end only with a result
  ready_with_result: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_J_ENABLE)
    else $error("READY without DATA_OUT_J_ENABLE");

  // Row start marks a result
  row_start_with_result: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_I_ENABLE |-> DATA_OUT_J_ENABLE)
    else $error("DATA_OUT_I_ENABLE without DATA_OUT_J_ENABLE");

  // Quiet outputs right after reset, before any START
  quiet_after_reset: assert property (@(posedge CLK)
    $fell(RST) |-> !out_any [*16])
    else $error("output strobe right after reset release");

  // One operation at a time
  start_only_idle: assert property (@(posedge CLK) disable iff (RST)
    START |-> !active)
    else $error("START while an operation runs");

endmodule

bind matrix_fixed_adder matrix_fixed_adder_asserts matrix_fixed_adder_asserts0 (
  .CLK              (CLK),
  .RST              (RST),
  .START            (START),
  .active           (active),
  .READY            (READY),
  .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
  .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE)
);

// ==== tb/matrix_fixed_adder_tb.sv ====
////////////////////
// Testbench for the matrix adder, cases read from the input data file
// Random skew and gaps on the operand strobes, results checked in order
////////////////////

`timescale 1ns/10ps

module matrix_fixed_adder_tb;

  logic                           CLK;
  logic                           RST;
  logic                           start;
  logic                           operation;
  logic                           a_i_enable;
  logic                           a_j_enable;
  logic                           b_i_enable;
  logic                           b_j_enable;
  logic [ntm_pkg::INDEX_SIZE-1:0] size_i;
  logic [ntm_pkg::INDEX_SIZE-1:0] size_j;
  logic [ntm_pkg::DATA_SIZE-1:0]  data_a;
  logic [ntm_pkg::DATA_SIZE-1:0]  data_b;
  logic                           ready;
  logic                           out_i_enable;
  logic                           out_j_enable;
  logic [ntm_pkg::DATA_SIZE-1:0]  data_out;

  // Cases from the file, elements kept flat
  string                         case_name [$];
  int                            case_op [$];
  int                            case_si [$];
  int                            case_sj [$];
  int                            case_base [$];
  logic [ntm_pkg::DATA_SIZE-1:0] a_q [$];
  logic [ntm_pkg::DATA_SIZE-1:0] b_q [$];
  logic [ntm_pkg::DATA_SIZE-1:0] exp_q [$];

  // Observed results
  logic [ntm_pkg::DATA_SIZE-1:0] res_data [$];
  logic                          res_i [$];
  logic                          res_ready [$];

  int cycles = 0;
  int cycle_limit = 200;

  matrix_fixed_adder dut0 (
    .CLK               (CLK),
    .RST               (RST),
    .START             (start),
    .READY             (ready),
    .OPERATION         (operation),
    .DATA_A_IN_I_ENABLE(a_i_enable),
    .DATA_A_IN_J_ENABLE(a_j_enable),
    .DATA_B_IN_I_ENABLE(b_i_enable),
    .DATA_B_IN_J_ENABLE(b_j_enable),
    .DATA_OUT_I_ENABLE (out_i_enable),
    .DATA_OUT_J_ENABLE (out_j_enable),
    .SIZE_I_IN         (size_i),
    .SIZE_J_IN         (size_j),
    .DATA_A_IN         (data_a),
    .DATA_B_IN         (data_b),
    .DATA_OUT          (data_out)
  );

  always #10 CLK = ~CLK;

  ////////////////////
  // Timeout and monitor
  ////////////////////

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: results still missing after %0d cycles", cycles);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  // Outputs sampled mid-cycle, well after the driving edge
  always @(negedge CLK) begin
    if (!RST && out_j_enable) begin
      res_data.push_back(data_out);
      res_i.push_back(out_i_enable);
      res_ready.push_back(ready);
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected 0x%0h actual 0x%0h", what, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Reference: full precision add or subtract, clamped to the Q8.8 range
  function automatic logic [ntm_pkg::DATA_SIZE-1:0] saturated_result(
    input int op, input logic [ntm_pkg::DATA_SIZE-1:0] a, input logic [ntm_pkg::DATA_SIZE-1:0] b
  );
    int sa;
    int sb;
    int r;
    sa = int'($signed(a));
    sb = int'($signed(b));
    r  = (op == int'(ntm_pkg::OP_SUB)) ? sa - sb : sa + sb;
    if (r > int'(ntm_pkg::DATA_MAX)) r = int'(ntm_pkg::DATA_MAX);
    if (r < int'(ntm_pkg::DATA_MIN)) r = int'(ntm_pkg::DATA_MIN);
    return r[ntm_pkg::DATA_SIZE-1:0];
  endfunction

  // One cycle of strobes, I enable on the first element of a row
  task automatic drive_cycle(input bit a_on, input int a_idx, input bit b_on, input int b_idx,
                             input int sj, input int base);
    @(posedge CLK);
    #2;
    start      = 1'b0;
    a_i_enable = a_on && (a_idx % sj == 0);
    a_j_enable = a_on && (a_idx % sj != 0);
    b_i_enable = b_on && (b_idx % sj == 0);
    b_j_enable = b_on && (b_idx % sj != 0);
    data_a     = a_on ? a_q[base + a_idx] : $urandom;
    data_b     = b_on ? b_q[base + b_idx] : $urandom;
  endtask

  // Random strobes while idle, all must be dropped
  task automatic send_idle_strobes(input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge CLK);
      #2;
      {a_i_enable, a_j_enable, b_i_enable, b_j_enable} = $urandom;
      data_a = $urandom;
      data_b = $urandom;
    end
    drive_cycle(0, 0, 0, 0, 1, 0);
    // Room for a leaked pair to come through the pipeline
    repeat (5) @(posedge CLK);
  endtask

  task automatic run_case(input int c);
    int  n;
    int  sj;
    int  base;
    int  i_count;
    bit  pending;
    n       = case_si[c] * case_sj[c];
    sj      = case_sj[c];
    base    = case_base[c];
    pending = 0;
    i_count = 0;
    check_value({case_name[c], " stray results"}, 0, res_data.size());
    @(posedge CLK);
    #2;
    start     = 1'b1;
    operation = case_op[c][0];
    size_i    = case_si[c];
    size_j    = case_sj[c];
    for (int e = 0; e < n; e++) begin
      // Optional gap, flushes a late B
      if ($urandom % 4 == 0) begin
        drive_cycle(0, 0, pending, e - 1, sj, base);
        pending = 0;
      end
      if (pending) begin
        drive_cycle(1, e, 1, e - 1, sj, base);
      end else if ($urandom % 2) begin
        drive_cycle(1, e, 0, 0, sj, base);
        pending = 1;
      end else begin
        drive_cycle(1, e, 1, e, sj, base);
      end
    end
    if (pending) drive_cycle(0, 0, 1, n - 1, sj, base);
    drive_cycle(0, 0, 0, 0, sj, base);
    while (res_data.size() < n) @(negedge CLK);
    // Data, row framing and matrix end in row-major order
    for (int e = 0; e < n; e++) begin
      check_value($sformatf("%s data %0d", case_name[c], e), exp_q[base + e], res_data[e]);
      check_value($sformatf("%s row start %0d", case_name[c], e), (e % sj == 0), res_i[e]);
      check_value($sformatf("%s ready %0d", case_name[c], e), (e == n - 1), res_ready[e]);
      i_count += res_i[e];
    end
    check_value({case_name[c], " row count"}, case_si[c], i_count);
    res_data.delete();
    res_i.delete();
    res_ready.delete();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int    fd;
    int    code;
    int    op_v;
    int    si_v;
    int    sj_v;
    string tok;
    string line;
    logic [ntm_pkg::DATA_SIZE-1:0] wa;
    logic [ntm_pkg::DATA_SIZE-1:0] wb;
    logic [ntm_pkg::DATA_SIZE-1:0] we;
    void'($urandom(17862));
    CLK        = 1'b0;
    RST        = 1'b1;
    start      = 1'b0;
    operation  = ntm_pkg::OP_ADD;
    a_i_enable = 1'b0;
    a_j_enable = 1'b0;
    b_i_enable = 1'b0;
    b_j_enable = 1'b0;
    size_i     = '0;
    size_j     = '0;
    data_a     = '0;
    data_b     = '0;
    fd = $fopen("tb/matrix_fixed_adder_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the input data file");
      $display("Result: FAILED");
      $fatal(1, "missing input file");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok[0] == "#") begin
        code = $fgets(line, fd);
        continue;
      end
      code = $fscanf(fd, "%d %d %d", op_v, si_v, sj_v);
      case_name.push_back(tok);
      case_op.push_back(op_v);
      case_si.push_back(si_v);
      case_sj.push_back(sj_v);
      case_base.push_back(a_q.size());
      for (int e = 0; e < si_v * sj_v; e++) begin
        code = $fscanf(fd, "%h %h %h", wa, wb, we);
        // File expectation must follow the saturation rule
        check_value($sformatf("%s file %0d", tok, e), saturated_result(op_v, wa, wb), we);
        a_q.push_back(wa);
        b_q.push_back(wb);
        exp_q.push_back(we);
      end
    end
    $fclose(fd);
    cycle_limit = a_q.size() * 4 + 200;
    repeat (16) @(posedge CLK);
    #2;
    RST = 1'b0;
    // Strobes before the first START
    send_idle_strobes(15);
    for (int c = 0; c < case_name.size(); c++) begin
      run_case(c);
      send_idle_strobes(2);
    end
    check_value("strobes while idle", 0, res_data.size());
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== matrix_fixed_adder.f ====
source/ntm_pkg.sv
source/scalar_fixed_adder.sv
source/vector_fixed_adder.sv
source/matrix_fixed_adder.sv
tb/matrix_fixed_adder_asserts.sv
tb/matrix_fixed_adder_tb.sv

// ==== Bender.yml ====
package:
  name: matrix_fixed_adder

sources:
  - source/ntm_pkg.sv
  - source/scalar_fixed_adder.sv
  - source/vector_fixed_adder.sv
  - source/matrix_fixed_adder.sv
  - target: simulation
    files:
      - tb/matrix_fixed_adder_asserts.sv
      - tb/matrix_fixed_adder_tb.sv

// ==== tb/matrix_fixed_adder_input.txt ====
# Per case: name, operation (0 add, 1 subtract), SIZE_I, SIZE_J
# then one line per matrix row of hex triples: A B expected
add_3x4 0 3 4
0100 0080 0180  0200 ff00 0100  0040 0040 0080  fff0 0010 0000
1000 0100 1100  8000 0001 8001  7f00 0080 7f80  ff80 ff80 ff00
0001 0002 0003  1234 1111 2345  0a00 f600 0000  0300 0280 0580
sub_2x2 1 2 2
0300 0100 0200  0100 0300 fe00
ff00 ff00 0000  0080 ff80 0100
sat_add_1x3 0 1 3
7f00 0200 7fff  4000 4000 7fff  8000 ff00 8000
sat_sub_2x1 1 2 1
8000 0100 8000
7f00 8000 7fff
one_1x1 0 1 1
0123 0456 0579
